/* compile.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/branch_target_buffer.sv
verilog/fetch_stage.sv
verilog/fetch_queue.sv
verilog/predecode_stage.sv
verilog/frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv

/* include/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ==============================
// Front end sizing
// ==============================

// First fetch address after reset, word aligned
`define FETCH_RESET_VECTOR 32'h0000_0100

// Direct-mapped prediction entries
// Must be a power of two, the index is taken straight from PC bits
`define FETCH_BTB_ENTRIES 8

// Fetch queue slots, power of two so the pointers wrap on their own
`define FETCH_QUEUE_DEPTH 4

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module frontend_tb -f compile.f -o frontend_sim

# Pass or fail is decided by the message, not by the exit code
result=$(./obj_dir/frontend_sim 2>&1) || true
printf '%s\n' "$result"

# Non-zero status from grep ends the script with a failure
printf '%s\n' "$result" | grep -qx "Simulation passed"
exit 0

/* verif/frontend_checker.sv */
module frontend_checker (
    input logic             clk_i,
    input logic             rst_ni,
    input logic             mem_req_valid_i,
    input logic             mem_req_ready_i,
    input fetch_pkg::addr_t mem_req_addr_i,
    input logic             mem_rsp_valid_i,
    input logic             dec_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic in_flight_q;

    // Set on acceptance, cleared by the matching response
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_flight_q <= 1'b0;
        end else if (mem_req_valid_i && mem_req_ready_i) begin
            in_flight_q <= 1'b1;
        end else if (mem_rsp_valid_i) begin
            in_flight_q <= 1'b0;
        end
    end

    // ==============================
    // Request channel
    // ==============================

    // Stalled request keeps valid and address
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_i && !mem_req_ready_i) |=>
        (mem_req_valid_i && $stable(mem_req_addr_i)))
        else $error("memory request dropped or changed while stalled");

    // Only one request in flight
    single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_i && mem_req_ready_i) |-> !in_flight_q)
        else $error("second memory request accepted before the response");

    // Both valids quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> (!dec_valid_i && !mem_req_valid_i))
        else $error("valid output raised during reset");

endmodule

bind frontend_top frontend_checker i_frontend_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .dec_valid_i     (dec_valid_o)
);

/* verif/frontend_tb.sv */
`include "fetch_config.svh"

module frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES       = 8;
    localparam int PLANNED_DELIVERIES = 80;
    // Generous budget per delivery covers stalls, refills and halt waits
    localparam int TIMEOUT_CYCLES     = PLANNED_DELIVERIES * 16 + RESET_CYCLES;
    localparam int BTB_IDX_W          = $clog2(`FETCH_BTB_ENTRIES);

    // Shadow prediction entry
    typedef struct packed {
        logic             valid;
        fetch_pkg::addr_t tag;
        fetch_pkg::addr_t target;
        logic             taken;
    } shadow_entry_t;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   redirect_i;
    fetch_pkg::addr_t       redirect_pc_i;
    fetch_pkg::bp_update_t  bp_update_i;
    logic                   mem_req_valid_o;
    logic                   mem_req_ready_i;
    fetch_pkg::addr_t       mem_req_addr_o;
    logic                   mem_rsp_valid_i;
    fetch_pkg::word_t       mem_rsp_data_i;
    logic                   mem_rsp_error_i;
    logic                   dec_valid_o;
    logic                   dec_ready_i;
    fetch_pkg::decode_out_t dec_out_o;

    logic [31:0]           lcg_state;
    int                    error_count;
    int                    delivered;
    int                    path_count;
    int                    cycle_count;
    fetch_pkg::addr_t      exp_pc;
    logic                  exp_halted;
    logic                  random_mode;
    logic                  random_redirects;
    logic                  dec_stall;
    logic                  redir_pending;
    fetch_pkg::addr_t      redir_pc;
    fetch_pkg::bp_update_t redir_update;
    logic                  pend_valid;
    fetch_pkg::addr_t      pend_addr;
    int                    pend_wait;
    shadow_entry_t         shadow [`FETCH_BTB_ENTRIES];

    frontend_top i_frontend_top (.*);

    always #2 clk_i = ~clk_i;

    // ==============================
    // Random source and memory
    // ==============================

    function automatic int rand_below(int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;
    endfunction

    // Word hashed from the full address with illegal patterns at a few spots
    function automatic fetch_pkg::word_t mem_word(fetch_pkg::addr_t addr);
        logic [31:0] h;
        logic [6:0]  opc;
        h = (addr ^ 32'h5A5A_0000) * 32'h9E37_79B9;
        if (addr == 32'h0000_010C) return 32'h0000_0000;
        if (addr == 32'h0000_0118) return 32'hFFFF_FFFF;
        if (addr == 32'h0000_0414) return 32'h0000_305B;
        case (h[31:28])
            4'd0:    opc = 7'b0000011;
            4'd1:    opc = 7'b0100011;
            4'd2:    opc = 7'b1100011;
            4'd3:    opc = 7'b1101111;
            4'd4:    opc = 7'b1100111;
            4'd5:    opc = 7'b0110011;
            4'd7:    opc = 7'b0110111;
            4'd8:    opc = 7'b0010111;
            4'd9:    opc = 7'b1110011;
            4'd10:   opc = 7'b0001111;
            default: opc = 7'b0010011;
        endcase
        return {h[24:0], opc};
    endfunction

    function automatic logic in_fault_window(fetch_pkg::addr_t addr);
        return (addr >= 32'h0000_3000) && (addr < 32'h0000_3100);
    endfunction

    // ==============================
    // Reference model
    // ==============================

    function automatic fetch_pkg::opcode_e classify(fetch_pkg::word_t instr);
        case (instr[6:0])
            7'h03:   return fetch_pkg::OPC_LOAD;
            7'h23:   return fetch_pkg::OPC_STORE;
            7'h63:   return fetch_pkg::OPC_BRANCH;
            7'h6F:   return fetch_pkg::OPC_JAL;
            7'h67:   return fetch_pkg::OPC_JALR;
            7'h33:   return fetch_pkg::OPC_OP;
            7'h13:   return fetch_pkg::OPC_OP_IMM;
            7'h37:   return fetch_pkg::OPC_LUI;
            7'h17:   return fetch_pkg::OPC_AUIPC;
            7'h73:   return fetch_pkg::OPC_SYSTEM;
            7'h0F:   return fetch_pkg::OPC_MISC_MEM;
            default: return fetch_pkg::OPC_INVALID;
        endcase
    endfunction

    function automatic fetch_pkg::bp_predict_t shadow_lookup(fetch_pkg::addr_t pc);
        shadow_entry_t         e;
        fetch_pkg::bp_predict_t p;
        e = shadow[pc[BTB_IDX_W+1:2]];
        p = '0;
        if (e.valid && e.taken && (e.tag == (pc >> (BTB_IDX_W + 2)))) begin
            p.taken  = 1'b1;
            p.target = e.target;
        end
        return p;
    endfunction

    function automatic fetch_pkg::decode_out_t expected_output(fetch_pkg::addr_t pc);
        fetch_pkg::decode_out_t o;
        o        = '0;
        o.pc     = pc;
        o.opcode = fetch_pkg::OPC_INVALID;
        // Misaligned entry carries no prediction
        if (pc[1:0] != 2'b00) begin
            o.cause = fetch_pkg::EXC_INSTR_MISALIGNED;
            return o;
        end
        o.predict = shadow_lookup(pc);
        if (in_fault_window(pc)) begin
            o.cause = fetch_pkg::EXC_INSTR_ACCESS_FAULT;
        end else begin
            o.instr  = mem_word(pc);
            o.opcode = classify(o.instr);
            o.cause  = (o.opcode == fetch_pkg::OPC_INVALID) ?
                       fetch_pkg::EXC_ILLEGAL_INSTR : fetch_pkg::EXC_NONE;
        end
        return o;
    endfunction

    task automatic compare_addr(input string name, input fetch_pkg::addr_t exp,
                                input fetch_pkg::addr_t act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_word(input string name, input fetch_pkg::word_t exp,
                                input fetch_pkg::word_t act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_opcode(input string name, input fetch_pkg::opcode_e exp,
                                  input fetch_pkg::opcode_e act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_cause(input string name, input fetch_pkg::exc_cause_e exp,
                                 input fetch_pkg::exc_cause_e act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_predict(input string name, input fetch_pkg::bp_predict_t exp,
                                   input fetch_pkg::bp_predict_t act);
        if (act !== exp) begin
            error_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // Sampled mid-cycle so a handshake seen here completes at the next rising edge
    always @(negedge clk_i) begin : compare_proc
        fetch_pkg::decode_out_t expected;
        if (rst_ni) begin
            if (dec_valid_o && dec_ready_i) begin
                if (exp_halted) begin
                    error_count++;
                    $display("ERROR: entry at pc %h delivered while fetch is halted",
                             dec_out_o.pc);
                end else begin
                    expected = expected_output(exp_pc);
                    compare_addr("dec_out_o.pc", expected.pc, dec_out_o.pc);
                    compare_word("dec_out_o.instr", expected.instr, dec_out_o.instr);
                    compare_opcode("dec_out_o.opcode", expected.opcode, dec_out_o.opcode);
                    compare_predict("dec_out_o.predict", expected.predict, dec_out_o.predict);
                    compare_cause("dec_out_o.cause", expected.cause, dec_out_o.cause);
                    // Faults stop the stream and other entries follow the prediction
                    if (expected.cause == fetch_pkg::EXC_INSTR_MISALIGNED ||
                        expected.cause == fetch_pkg::EXC_INSTR_ACCESS_FAULT) begin
                        exp_halted = 1'b1;
                    end else if (expected.predict.taken) begin
                        exp_pc = expected.predict.target;
                    end else begin
                        exp_pc = exp_pc + 32'd4;
                    end
                end
                delivered++;
                path_count++;
            end
            // Entry popped above still belonged to the old path
            if (redirect_i) begin
                exp_pc     = redirect_pc_i;
                exp_halted = 1'b0;
                path_count = 0;
            end
            if (bp_update_i.valid) begin
                shadow[bp_update_i.pc[BTB_IDX_W+1:2]] = '{1'b1,
                    bp_update_i.pc >> (BTB_IDX_W + 2), bp_update_i.target, bp_update_i.taken};
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles with %0d entries delivered",
                     cycle_count, delivered);
            $display("Simulation failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    // One cycle of memory model and input drive
    task automatic step_cycle();
        @(negedge clk_i);
        if (mem_req_valid_o && mem_req_ready_i) begin
            pend_valid = 1'b1;
            pend_addr  = mem_req_addr_o;
            pend_wait  = random_mode ? 1 + rand_below(3) : 1;
        end
        @(posedge clk_i);
        #1;
        redirect_i      = 1'b0;
        bp_update_i     = '0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        mem_rsp_error_i = 1'b0;
        if (pend_valid) begin
            pend_wait--;
            if (pend_wait == 0) begin
                pend_valid      = 1'b0;
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = mem_word(pend_addr);
                mem_rsp_error_i = in_fault_window(pend_addr);
            end
        end
        mem_req_ready_i = random_mode ? (rand_below(4) != 0) : 1'b1;
        dec_ready_i     = random_mode ? (rand_below(10) < 7) : !dec_stall;
        if (redir_pending) begin
            redir_pending = 1'b0;
            redirect_i    = 1'b1;
            redirect_pc_i = redir_pc;
            bp_update_i   = redir_update;
        end else if (random_redirects && rand_below(32) == 0) begin
            redirect_i    = 1'b1;
            redirect_pc_i = 32'h0000_1000 | {20'd0, 10'(rand_below(1024)), 2'b00};
        end
    endtask

    // Second cycle lets the redirect reach the comparing process
    task automatic redirect_to(input fetch_pkg::addr_t pc, input fetch_pkg::bp_update_t upd);
        redir_pending = 1'b1;
        redir_pc      = pc;
        redir_update  = upd;
        step_cycle();
        step_cycle();
    endtask

    task automatic run_path(input int n);
        while (path_count < n) begin
            step_cycle();
        end
    endtask

    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        redirect_i       = 1'b0;
        redirect_pc_i    = '0;
        bp_update_i      = '0;
        mem_req_ready_i  = 1'b0;
        mem_rsp_valid_i  = 1'b0;
        mem_rsp_data_i   = '0;
        mem_rsp_error_i  = 1'b0;
        dec_ready_i      = 1'b0;
        lcg_state        = 32'd84112;
        error_count      = 0;
        delivered        = 0;
        path_count       = 0;
        cycle_count      = 0;
        exp_pc           = `FETCH_RESET_VECTOR;
        exp_halted       = 1'b0;
        random_mode      = 1'b0;
        random_redirects = 1'b0;
        dec_stall        = 1'b0;
        redir_pending    = 1'b0;
        redir_pc         = '0;
        redir_update     = '0;
        pend_valid       = 1'b0;
        pend_addr        = '0;
        pend_wait        = 0;
        for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Sequential stream with two illegal words on the way
        run_path(12);

        // Decode held off long enough for the queue to fill and fetch to stop
        dec_stall = 1'b1;
        repeat (20) step_cycle();
        dec_stall = 1'b0;

        // Random stalls on both sides plus random redirects
        random_mode      = 1'b1;
        random_redirects = 1'b1;
        while (delivered < 52) begin
            step_cycle();
        end
        random_redirects = 1'b0;

        // Taken entry at 0x408 and then cleared back to sequential
        redirect_to(32'h0000_0400, '{1'b1, 32'h0000_0408, 1'b1, 32'h0000_0600});
        run_path(10);
        redirect_to(32'h0000_0400, '{1'b1, 32'h0000_0408, 1'b0, 32'h0000_0000});
        run_path(8);

        // Misaligned target and then a fetch into the fault window
        redirect_to(32'h0000_0802, '0);
        run_path(1);
        repeat (24) step_cycle();
        redirect_to(32'h0000_2FF8, '0);
        run_path(3);
        repeat (24) step_cycle();

        // Redirect releases the halt
        redirect_to(32'h0000_0200, '0);
        run_path(6);

        $display("Checked %0d deliveries, %0d errors", delivered, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/branch_target_buffer.sv */
`include "fetch_config.svh"

module branch_target_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  fetch_pkg::addr_t      lookup_pc_i,
    output fetch_pkg::bp_predict_t predict_o,
    input  fetch_pkg::bp_update_t update_i
);

    // ==============================
    // Entry storage
    // ==============================

    // Valid bits are control state, the rest is payload
    logic                              valid_q  [0:`FETCH_BTB_ENTRIES-1];
    logic [fetch_pkg::BTB_TAG_W-1:0]   tag_q    [0:`FETCH_BTB_ENTRIES-1];
    fetch_pkg::addr_t                  target_q [0:`FETCH_BTB_ENTRIES-1];
    logic                              taken_q  [0:`FETCH_BTB_ENTRIES-1];

    logic [fetch_pkg::BTB_IDX_W-1:0] lookup_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] lookup_tag;
    logic [fetch_pkg::BTB_IDX_W-1:0] update_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] update_tag;
    logic                            lookup_hit;

    // Split both addresses into index and tag
    assign lookup_idx = lookup_pc_i[fetch_pkg::BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[31:fetch_pkg::BTB_IDX_W+2];
    assign update_idx = update_i.pc[fetch_pkg::BTB_IDX_W+1:2];
    assign update_tag = update_i.pc[31:fetch_pkg::BTB_IDX_W+2];

    // ==============================
    // Lookup
    // ==============================

    assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

    // Taken only on a tag hit with the taken bit set
    // Target reads as zero otherwise so the result is always defined
    assign predict_o.taken  = lookup_hit && taken_q[lookup_idx];
    assign predict_o.target = predict_o.taken ? target_q[lookup_idx] : '0;

    // Update overwrites the indexed entry, seen by lookups next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (update_i.valid) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_i.target;
            taken_q[update_idx]  <= update_i.taken;
        end
    end

endmodule

/* verilog/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    // ==============================
    // Derived widths
    // ==============================

    // Index sits just above the two zero bits of a word address
    localparam int BTB_IDX_W   = $clog2(`FETCH_BTB_ENTRIES);
    localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;
    localparam int QUEUE_PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
    // One extra bit so a full queue is distinct from an empty one
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Fetch faults plus the illegal instruction found at predecode
    typedef enum logic [1:0] {
        EXC_NONE               = 2'd0,
        EXC_INSTR_MISALIGNED   = 2'd1,
        EXC_INSTR_ACCESS_FAULT = 2'd2,
        EXC_ILLEGAL_INSTR      = 2'd3
    } exc_cause_e;

    // RV32 major opcode classes
    typedef enum logic [3:0] {
        OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_OP,
        OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_SYSTEM, OPC_MISC_MEM,
        OPC_INVALID
    } opcode_e;

    // ==============================
    // Structs
    // ==============================

    // Resolved branch outcome coming back from execute
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } bp_update_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } bp_predict_t;

    // One queue slot, fault limited to none, misaligned or access fault
    typedef struct packed {
        addr_t       pc;
        word_t       instr;
        bp_predict_t predict;
        exc_cause_e  fault;
    } fetch_entry_t;

    typedef struct packed {
        addr_t       pc;
        word_t       instr;
        opcode_e     opcode;
        bp_predict_t predict;
        exc_cause_e  cause;
    } decode_out_t;

endpackage

/* verilog/fetch_queue.sv */
`include "fetch_config.svh"

module fetch_queue (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              push_i,
    input  fetch_pkg::fetch_entry_t           push_entry_i,
    output logic [fetch_pkg::QUEUE_CNT_W-1:0] count_o,
    output logic                              not_empty_o,
    output fetch_pkg::fetch_entry_t           head_o,
    input  logic                              pop_i
);

    fetch_pkg::fetch_entry_t mem_q [0:`FETCH_QUEUE_DEPTH-1];

    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::QUEUE_CNT_W-1:0] count_q;
    logic                              full;
    logic                              do_push;
    logic                              do_pop;

    assign full        = (count_q == fetch_pkg::QUEUE_CNT_W'(`FETCH_QUEUE_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign count_o     = count_q;
    assign head_o      = mem_q[rd_ptr_q];

    // Push into a full queue only when a slot frees in the same cycle
    assign do_push = push_i && (!full || pop_i);
    assign do_pop  = pop_i && not_empty_o;

    // ==============================
    // Pointers and count
    // ==============================

    // Flush wins over push and pop, the popped entry has already left
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap naturally at a power-of-two depth
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Slot storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

endmodule

/* verilog/fetch_stage.sv */
`include "fetch_config.svh"

module fetch_stage (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              redirect_i,
    input  fetch_pkg::addr_t                  redirect_pc_i,
    input  fetch_pkg::bp_update_t             bp_update_i,
    output logic                              mem_req_valid_o,
    input  logic                              mem_req_ready_i,
    output fetch_pkg::addr_t                  mem_req_addr_o,
    input  logic                              mem_rsp_valid_i,
    input  fetch_pkg::word_t                  mem_rsp_data_i,
    input  logic                              mem_rsp_error_i,
    input  logic [fetch_pkg::QUEUE_CNT_W-1:0] queue_count_i,
    output logic                              push_o,
    output fetch_pkg::fetch_entry_t           push_entry_o
);

    fetch_pkg::addr_t       pc_q;
    fetch_pkg::addr_t       pc_d;
    fetch_pkg::addr_t       req_addr_q;
    fetch_pkg::bp_predict_t req_predict_q;
    fetch_pkg::bp_predict_t predict;
    logic req_valid_q;
    logic outstanding_q;
    logic stale_q;
    logic halt_q;
    logic idle;
    logic queue_space;
    logic pc_aligned;
    logic issue;
    logic req_fire;
    logic rsp_fire;
    logic rsp_push;
    logic mis_push;

    branch_target_buffer i_branch_target_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_pc_i (pc_q),
        .predict_o   (predict),
        .update_i    (bp_update_i)
    );

    // ==============================
    // Request control
    // ==============================

    // Nothing presented and nothing in flight
    assign idle        = !req_valid_q && !outstanding_q;
    assign queue_space = queue_count_i < fetch_pkg::QUEUE_CNT_W'(`FETCH_QUEUE_DEPTH);
    assign pc_aligned  = (pc_q[1:0] == 2'b00);

    // Launch a request; it is then held in registers until accepted
    assign issue    = idle && queue_space && pc_aligned && !halt_q && !redirect_i;
    assign req_fire = req_valid_q && mem_req_ready_i;
    assign rsp_fire = mem_rsp_valid_i && outstanding_q;

    // Stale or redirect-cycle responses are dropped
    assign rsp_push = rsp_fire && !stale_q && !redirect_i;
    // Misaligned PC waits for an idle port so queue order is kept
    assign mis_push = idle && queue_space && !pc_aligned && !halt_q && !redirect_i;

    assign mem_req_valid_o = req_valid_q;
    assign mem_req_addr_o  = req_addr_q;

    // Next PC: redirect, then taken prediction, then sequential
    always_comb begin
        pc_d = pc_q;
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (issue) begin
            pc_d = predict.taken ? predict.target : pc_q + 32'd4;
        end
    end

    // ==============================
    // Queue entry
    // ==============================

    assign push_o = rsp_push || mis_push;

    always_comb begin
        push_entry_o = '0;
        if (mis_push) begin
            push_entry_o.pc    = pc_q;
            push_entry_o.fault = fetch_pkg::EXC_INSTR_MISALIGNED;
        end else begin
            push_entry_o.pc      = req_addr_q;
            push_entry_o.predict = req_predict_q;
            // Faulted word is zeroed
            if (mem_rsp_error_i) begin
                push_entry_o.fault = fetch_pkg::EXC_INSTR_ACCESS_FAULT;
            end else begin
                push_entry_o.instr = mem_rsp_data_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q          <= `FETCH_RESET_VECTOR;
            req_valid_q   <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
            halt_q        <= 1'b0;
        end else begin
            pc_q <= pc_d;
            if (issue) begin
                req_valid_q <= 1'b1;
            end else if (req_fire) begin
                req_valid_q <= 1'b0;
            end
            if (req_fire) begin
                outstanding_q <= 1'b1;
            end else if (rsp_fire) begin
                outstanding_q <= 1'b0;
            end
            if (rsp_fire) begin
                stale_q <= 1'b0;
            end
            // A presented or unanswered request belongs to the old path
            if (redirect_i && (req_valid_q || (outstanding_q && !mem_rsp_valid_i))) begin
                stale_q <= 1'b1;
            end
            if (redirect_i) begin
                halt_q <= 1'b0;
            end else if (mis_push || (rsp_push && mem_rsp_error_i)) begin
                halt_q <= 1'b1;
            end
        end
    end

    // Request payload, captured at launch
    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_addr_q    <= pc_q;
            req_predict_q <= predict;
        end
    end

endmodule

/* verilog/frontend_top.sv */
module frontend_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   redirect_i,
    input  fetch_pkg::addr_t       redirect_pc_i,
    input  fetch_pkg::bp_update_t  bp_update_i,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output fetch_pkg::addr_t       mem_req_addr_o,
    input  logic                   mem_rsp_valid_i,
    input  fetch_pkg::word_t       mem_rsp_data_i,
    input  logic                   mem_rsp_error_i,
    output logic                   dec_valid_o,
    input  logic                   dec_ready_i,
    output fetch_pkg::decode_out_t dec_out_o
);

    // ==============================
    // Stage to stage wiring
    // ==============================

    logic [fetch_pkg::QUEUE_CNT_W-1:0] queue_count;
    logic                              push;
    fetch_pkg::fetch_entry_t           push_entry;
    logic                              not_empty;
    fetch_pkg::fetch_entry_t           head;
    logic                              pop;

    // Producer side, PC and memory port
    fetch_stage i_fetch_stage (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .bp_update_i     (bp_update_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_rsp_error_i (mem_rsp_error_i),
        .queue_count_i   (queue_count),
        .push_o          (push),
        .push_entry_o    (push_entry)
    );

    // Redirect empties the queue at the same edge the PC reloads
    fetch_queue i_fetch_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (redirect_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .count_o      (queue_count),
        .not_empty_o  (not_empty),
        .head_o       (head),
        .pop_i        (pop)
    );

    predecode_stage i_predecode_stage (
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .dec_valid_o (dec_valid_o),
        .dec_ready_i (dec_ready_i),
        .dec_out_o   (dec_out_o)
    );

endmodule

/* verilog/predecode_stage.sv */
module predecode_stage (
    input  logic                    not_empty_i,
    input  fetch_pkg::fetch_entry_t head_i,
    output logic                    pop_o,
    output logic                    dec_valid_o,
    input  logic                    dec_ready_i,
    output fetch_pkg::decode_out_t  dec_out_o
);

    fetch_pkg::opcode_e opcode;
    logic               faulted;

    assign faulted = (head_i.fault != fetch_pkg::EXC_NONE);

    // Head goes straight to decode, popped on the handshake
    assign dec_valid_o = not_empty_i;
    assign pop_o       = not_empty_i && dec_ready_i;

    // ==============================
    // Opcode class
    // ==============================

    // Bits 1..0 must be 2'b11 for a 32-bit RV32 instruction
    always_comb begin
        opcode = fetch_pkg::OPC_INVALID;
        if (head_i.instr[1:0] == 2'b11) begin
            case (head_i.instr[6:2])
                5'b00000: opcode = fetch_pkg::OPC_LOAD;
                5'b01000: opcode = fetch_pkg::OPC_STORE;
                5'b11000: opcode = fetch_pkg::OPC_BRANCH;
                5'b11011: opcode = fetch_pkg::OPC_JAL;
                5'b11001: opcode = fetch_pkg::OPC_JALR;
                5'b01100: opcode = fetch_pkg::OPC_OP;
                5'b00100: opcode = fetch_pkg::OPC_OP_IMM;
                5'b01101: opcode = fetch_pkg::OPC_LUI;
                5'b00101: opcode = fetch_pkg::OPC_AUIPC;
                5'b11100: opcode = fetch_pkg::OPC_SYSTEM;
                5'b00011: opcode = fetch_pkg::OPC_MISC_MEM;
                default:  opcode = fetch_pkg::OPC_INVALID;
            endcase
        end
    end

    // Fetch fault first, then illegal opcode
    always_comb begin
        dec_out_o.pc      = head_i.pc;
        dec_out_o.predict = head_i.predict;
        if (faulted) begin
            dec_out_o.instr  = '0;
            dec_out_o.opcode = fetch_pkg::OPC_INVALID;
            dec_out_o.cause  = head_i.fault;
        end else begin
            dec_out_o.instr  = head_i.instr;
            dec_out_o.opcode = opcode;
            dec_out_o.cause  = (opcode == fetch_pkg::OPC_INVALID) ?
                               fetch_pkg::EXC_ILLEGAL_INSTR : fetch_pkg::EXC_NONE;
        end
    end

endmodule
